// ==== verilog.f ====
source/dnn_geometry_pkg.sv
source/fixed_point_pkg.sv
source/ideal_output_delay.sv
source/cost_term_stage.sv
source/delta_bank_ctrl.sv
source/delta_pingpong_mem.sv
source/output_layer_top.sv
verif/output_layer_properties.sv
verif/tb_output_layer.sv

// ==== Bender.yml ====
package:
  name: output_layer

sources:
  # Packages first, the format package imports the geometry package
  - source/dnn_geometry_pkg.sv
  - source/fixed_point_pkg.sv
  # Pipeline stages
  - source/ideal_output_delay.sv
  - source/cost_term_stage.sv
  - source/delta_bank_ctrl.sv
  - source/delta_pingpong_mem.sv
  # Top level
  - source/output_layer_top.sv
  # Verification, top module tb_output_layer
  - target: verif
    files:
      - verif/output_layer_properties.sv
      - verif/tb_output_layer.sv

// ==== verif/tb_output_layer.sv ====
// Output junction testbench with clock, reset, slot counter, row stimulus, test report and timeout
`timescale 1ns/100ps

module tb_output_layer
	import dnn_geometry_pkg::*, fixed_point_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CLKS   = CLKS_PER_CYCLE + 2; // Lets the last rows reach del_o

	// Test lengths in clocks
	localparam int LEN_RESET = CLKS_PER_CYCLE;
	localparam int LEN_DELAY = 4 * CLKS_PER_CYCLE;
	localparam int LEN_ROUND = 10 * CLKS_PER_CYCLE;
	localparam int LEN_SAT   = 4 * CLKS_PER_CYCLE; // Longer than ANS_DELAY so bits line up
	localparam int LEN_BANK  = 4 * CLKS_PER_CYCLE;
	localparam int RUN_CLKS  = RESET_CYCLES + LEN_RESET + LEN_DELAY + LEN_ROUND
		+ LEN_SAT + LEN_BANK + 5 * DRAIN_CLKS;
	localparam int TIMEOUT_CLKS = 2 * RUN_CLKS;

	// Stimulus kinds
	localparam int MODE_IDLE     = 0; // Zero rows, ideal bits clear
	localparam int MODE_RAND_ANS = 1; // Random ideal bits, fixed activation
	localparam int MODE_RAND_ACT = 2; // Random activations in 0.0 to 1.0, random bits
	localparam int MODE_SAT      = 3; // Even lanes near FIX_MIN, odd lanes near FIX_MAX
	localparam int MODE_ROW_TAG  = 4; // Unique value per clock and lane

	logic        clk;
	logic        rst_n_i;
	cycle_idx_t  cycle_index_i;
	fix_vec_t    act_i;
	ans_vec_t    ans_i;
	fix_vec_t    del_o;
	ans_vec_t    ans_o;

	int          tests_run;
	int          tests_ok;
	int unsigned cycle_cnt; // Timeout counter

	output_layer_top u_dut (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cycle_index_i (cycle_index_i),
		.act_i         (act_i),
		.ans_i         (ans_i),
		.del_o         (del_o),
		.ans_o         (ans_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// Network-wide slot counter, runs through reset as well
	always @(posedge clk) begin
		if (cycle_index_i == cycle_idx_t'(CLKS_PER_CYCLE - 1)) begin
			cycle_index_i <= '0;
		end else begin
			cycle_index_i <= cycle_index_i + 1'b1;
		end
	end

	// Hard stop well past the expected run length
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CLKS) begin
			$display("Timeout after %0d clocks, the test sequence did not finish", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	// Drive one row per clock of the chosen kind
	task automatic drive_rows(input int n_clocks, input int mode);
		fix_vec_t act_nxt;
		ans_vec_t ans_nxt;
		for (int n = 0; n < n_clocks; n++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				case (mode)
					MODE_RAND_ANS: begin
						act_nxt[l] = fix_t'(int'(FIX_ONE) / 2); // 0.5
						ans_nxt[l] = ($urandom_range(1) != 0);
					end
					MODE_RAND_ACT: begin
						act_nxt[l] = fix_t'($urandom_range(int'(FIX_ONE)));
						ans_nxt[l] = ($urandom_range(1) != 0);
					end
					MODE_SAT: begin
						if (l % 2 == 0) begin
							act_nxt[l] = fix_t'(int'(FIX_MIN) + int'($urandom_range(int'(FIX_ONE) - 1)));
							ans_nxt[l] = 1'b1; // Pushes below FIX_MIN
						end else begin
							act_nxt[l] = fix_t'(int'(FIX_MAX) - int'($urandom_range(int'(FIX_ONE) - 1)));
							ans_nxt[l] = 1'b0; // Passes unchanged
						end
					end
					MODE_ROW_TAG: begin
						act_nxt[l] = fix_t'((n << 3) | l); // Wrong bank shows as a wrong tag
						ans_nxt[l] = 1'b0;
					end
					default: begin
						act_nxt[l] = '0;
						ans_nxt[l] = 1'b0;
					end
				endcase
			end
			@(posedge clk);
			act_i <= act_nxt;
			ans_i <= ans_nxt;
		end
	endtask

	// Stimulus, drain, then one result line from the assertion failure count
	task automatic run_test(input string name, input int mode, input int n_clocks);
		int fails_before;
		int fails_new;
		fails_before = u_dut.u_props.fail_count;
		drive_rows(n_clocks, mode);
		drive_rows(DRAIN_CLKS, MODE_IDLE);
		@(negedge clk); // Assertion actions of the last edge have run
		fails_new = u_dut.u_props.fail_count - fails_before;
		tests_run++;
		if (fails_new == 0) begin
			tests_ok++;
			$display("[%0t] %-16s ok", $time, name);
		end else begin
			$display("[%0t] %-16s FAILED, %0d assertion failures", $time, name, fails_new);
		end
	endtask

	initial begin
		void'($urandom(32'ha992)); // One seed for the whole run
		rst_n_i       = 1'b0;
		cycle_index_i = '0;
		act_i         = '0;
		ans_i         = '0;
		tests_run     = 0;
		tests_ok      = 0;
		cycle_cnt     = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;

		run_test("reset_quiet", MODE_IDLE, LEN_RESET);
		run_test("ideal_delay", MODE_RAND_ANS, LEN_DELAY);
		run_test("round_trip", MODE_RAND_ACT, LEN_ROUND);
		run_test("saturation", MODE_SAT, LEN_SAT);
		run_test("bank_alternation", MODE_ROW_TAG, LEN_BANK);

		$display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
			tests_run, tests_ok, tests_run - tests_ok, u_dut.u_props.fail_count);
		if (tests_ok == tests_run && u_dut.u_props.fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== verif/output_layer_properties.sv ====
// Bound assertions on the output junction and the failure counter read by the testbench
`timescale 1ns/100ps

module output_layer_properties
	import dnn_geometry_pkg::*, fixed_point_pkg::*;
(
	input logic       clk,
	input logic       rst_n_i,
	input cycle_idx_t cycle_index_i, // Slot counter as driven
	input fix_vec_t   act_i,         // Activations as driven
	input ans_vec_t   ans_i,         // Ideal bits as driven
	input ans_vec_t   ans_o,         // Delayed ideal bits from the DUT
	input fix_vec_t   del_o,         // Errors read back from the delta memory
	input bank_sel_e  wr_bank,       // Internal write bank pointer
	input lane_we_t   wr_en,         // Internal lane write enables
	input row_addr_t  rd_addr        // Internal read row
);

	localparam int RT_LAT = CLKS_PER_CYCLE + 1; // Activation slot to del_o

	int          fail_count = 0;        // Read by the testbench after each test
	int unsigned since_rst;             // Clocks out of reset
	fix_vec_t    exp_del  [RT_LAT];     // Expected errors in flight
	logic        exp_vld  [RT_LAT];     // Entry was taken in a row slot
	ans_vec_t    ans_hist [ANS_DELAY];  // Ideal bits as they were driven
	ans_vec_t    ans_exp;               // Expected ans_o
	lane_we_t    wr_en_exp;             // Expected write enables

	// Activation minus 0.0 or 1.0, clamped to the signed 16-bit range
	function automatic fix_t cross_entropy_err(input fix_t act, input logic ideal);
		int diff;
		diff = int'(act) - (ideal ? (1 << FRAC_BITS) : 0);
		if (diff > 2 ** (DATA_WIDTH - 1) - 1) begin
			diff = 2 ** (DATA_WIDTH - 1) - 1; // Positive limit
		end else if (diff < -(2 ** (DATA_WIDTH - 1))) begin
			diff = -(2 ** (DATA_WIDTH - 1)); // Negative limit
		end
		return fix_t'(diff);
	endfunction

	// Clocks since reset and which history entries came from row slots
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			since_rst <= 0;
			for (int i = 0; i < RT_LAT; i++) begin
				exp_vld[i] <= 1'b0;
			end
		end else begin
			since_rst  <= since_rst + 1;
			exp_vld[0] <= (cycle_index_i < cycle_idx_t'(ROWS_PER_BANK)); // Row slot taken
			for (int i = 1; i < RT_LAT; i++) begin
				exp_vld[i] <= exp_vld[i-1];
			end
		end
	end

	// Data histories, gated by the flags above
	always_ff @(posedge clk) begin
		ans_hist[0] <= ans_i;
		for (int i = 1; i < ANS_DELAY; i++) begin
			ans_hist[i] <= ans_hist[i-1];
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			exp_del[0][l] <= cross_entropy_err(act_i[l], ans_exp[l]); // Modelled bit, same edge
		end
		for (int i = 1; i < RT_LAT; i++) begin
			exp_del[i] <= exp_del[i-1];
		end
	end

	assign ans_exp   = (since_rst >= ANS_DELAY) ? ans_hist[ANS_DELAY-1] : '0; // Zero until filled
	assign wr_en_exp = {NUM_LANES{exp_vld[0]}}; // Clock after a row slot only

	a_wr_en_slots: assert property (@(posedge clk) disable iff (!rst_n_i) wr_en == wr_en_exp)
		else begin
			$error("** Error at %0t: wr_en got %b expected %b",
				$time, $sampled(wr_en), $sampled(wr_en_exp));
			fail_count++;
		end

	a_ans_delay: assert property (@(posedge clk) disable iff (!rst_n_i) ans_o == ans_exp)
		else begin
			$error("** Error at %0t: ans_o got %b expected %b",
				$time, $sampled(ans_o), $sampled(ans_exp));
			fail_count++;
		end

	a_round_trip: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_vld[RT_LAT-1] |-> del_o == exp_del[RT_LAT-1])
		else begin
			$error("** Error at %0t: del_o got %h expected %h",
				$time, $sampled(del_o), $sampled(exp_del[RT_LAT-1]));
			fail_count++;
		end

	// BANK_0 right after reset, then a flip only on the edge that ends the last slot
	a_bank_swap: assert property (@(posedge clk) disable iff (!rst_n_i)
		(since_rst == 0) ? (wr_bank == BANK_0)
			: ((wr_bank != $past(wr_bank))
				== ($past(cycle_index_i) == cycle_idx_t'(CLKS_PER_CYCLE - 1))))
		else begin
			$error("Bank pointer wr_bank did not follow the cycle index wrap at %0t", $time);
			fail_count++;
		end

	// Read row follows the slot, the memory reads the bank not named by wr_bank
	a_read_row: assert property (@(posedge clk) disable iff (!rst_n_i)
		cycle_index_i < cycle_idx_t'(ROWS_PER_BANK) |-> rd_addr == row_addr_t'(cycle_index_i))
		else begin
			$error("** Error at %0t: rd_addr got %0d expected %0d",
				$time, $sampled(rd_addr), $sampled(cycle_index_i));
			fail_count++;
		end

endmodule

// Attach the checks to every output junction instance
bind output_layer_top output_layer_properties u_props (
	.clk           (clk),
	.rst_n_i       (rst_n_i),
	.cycle_index_i (cycle_index_i),
	.act_i         (act_i),
	.ans_i         (ans_i),
	.ans_o         (ans_o),
	.del_o         (del_o),
	.wr_bank       (wr_bank),
	.wr_en         (wr_en),
	.rd_addr       (rd_addr)
);

// ==== source/output_layer_top.sv ====
// Output-layer junction top: ideal bit delay, cost term, bank control and ping-pong delta memory
`timescale 1ns/100ps

module output_layer_top
	import dnn_geometry_pkg::*, fixed_point_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  cycle_idx_t cycle_index_i, // Network-wide slot counter
	input  fix_vec_t   act_i,         // Activations from the last layer
	input  ans_vec_t   ans_i,         // Ideal bits from the first layer
	output fix_vec_t   del_o,         // Errors back to the previous layer
	output ans_vec_t   ans_o          // Ideal bits aligned with act_i
);

	fix_vec_t  cost_del; // Registered error terms
	bank_sel_e wr_bank;  // Bank written this cycle
	lane_we_t  wr_en;
	row_addr_t wr_addr;
	row_addr_t rd_addr;

	// Align ideal bits with the sample's activations
	ideal_output_delay u_ans_delay (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.ans_i   (ans_i),
		.ans_o   (ans_o)
	);

	// Activation minus ideal value, saturated
	cost_term_stage u_cost (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.act_i   (act_i),
		.ans_i   (ans_o),
		.del_o   (cost_del)
	);

	// Bank pointer and addresses from the slot counter
	delta_bank_ctrl u_bank_ctrl (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cycle_index_i (cycle_index_i),
		.wr_bank_o     (wr_bank),
		.wr_en_o       (wr_en),
		.wr_addr_o     (wr_addr),
		.rd_addr_o     (rd_addr)
	);

	// Errors written this cycle, read back next cycle
	delta_pingpong_mem u_delta_mem (
		.clk       (clk),
		.wr_bank_i (wr_bank),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (cost_del),
		.rd_addr_i (rd_addr),
		.rd_data_o (del_o)
	);

endmodule

// ==== source/delta_pingpong_mem.sv ====
// Two-bank per-lane error storage, write to the selected bank and registered read of the other
`timescale 1ns/100ps

module delta_pingpong_mem
	import dnn_geometry_pkg::*, fixed_point_pkg::*;
(
	input  logic      clk,
	input  bank_sel_e wr_bank_i, // Bank filled this junction cycle
	input  lane_we_t  wr_en_i,   // Per-lane write enables
	input  row_addr_t wr_addr_i, // Write row
	input  fix_vec_t  wr_data_i, // Error terms from the cost stage
	input  row_addr_t rd_addr_i, // Read row in the other bank
	output fix_vec_t  rd_data_o  // Errors of the previous cycle, to the previous layer
);

	// Storage indexed as bank, lane, row
	fix_t      bank_mem [2][NUM_LANES][ROWS_PER_BANK];
	bank_sel_e rd_bank; // Bank holding last cycle's errors

	// Read always targets the bank not being written
	assign rd_bank = (wr_bank_i == BANK_0) ? BANK_1 : BANK_0;

	// Write port, one enable per lane
	always_ff @(posedge clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (wr_en_i[l]) begin
				bank_mem[wr_bank_i][l][wr_addr_i] <= wr_data_i[l];
			end
		end
	end

	// Registered read port, data one clock after the address
	always_ff @(posedge clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			rd_data_o[l] <= bank_mem[rd_bank][l][rd_addr_i];
		end
	end

endmodule

// ==== source/delta_bank_ctrl.sv ====
// Ping-pong bank pointer, write and read row addresses and lane write enables from the cycle index
`timescale 1ns/100ps

module delta_bank_ctrl
	import dnn_geometry_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  cycle_idx_t cycle_index_i, // Shared slot counter, 0 to CLKS_PER_CYCLE-1
	output bank_sel_e  wr_bank_o,     // Bank written in this junction cycle
	output lane_we_t   wr_en_o,       // Active one clock after a row slot
	output row_addr_t  wr_addr_o,     // Row of the value now at the write port
	output row_addr_t  rd_addr_o      // Row read from the other bank this slot
);

	bank_sel_e wr_bank_q; // Bank pointer, the only state machine here
	logic      row_slot;  // Current slot carries a row of activations
	logic      last_slot; // Final slot of the junction cycle
	row_addr_t slot_row;  // Slot number cut to a row address

	assign row_slot  = (cycle_index_i < cycle_idx_t'(ROWS_PER_BANK));
	assign last_slot = (cycle_index_i == cycle_idx_t'(CLKS_PER_CYCLE - 1));
	assign slot_row  = cycle_index_i[ROW_ADDR_W-1:0];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_bank_q <= BANK_0; // Start writing bank 0
			wr_en_o   <= '0;
			wr_addr_o <= '0;
		end else begin
			// Swap banks on the cycle index wrap
			if (last_slot) begin
				wr_bank_q <= (wr_bank_q == BANK_0) ? BANK_1 : BANK_0;
			end

			// The error term arrives one clock after its row slot
			wr_en_o <= {NUM_LANES{row_slot}};
			if (row_slot) begin
				wr_addr_o <= slot_row; // Hold last row in the spare slots
			end
		end
	end

	assign wr_bank_o = wr_bank_q;

	// Read side follows the slot directly, the memory adds the register
	assign rd_addr_o = row_slot ? slot_row : '0;

endmodule

// ==== source/cost_term_stage.sv ====
// Registered per-lane cross-entropy error term, activation minus ideal value with saturation
`timescale 1ns/100ps

module cost_term_stage
	import dnn_geometry_pkg::*, fixed_point_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n_i,
	input  fix_vec_t act_i, // Last-layer activations, one row
	input  ans_vec_t ans_i, // Delayed ideal bits for the same row
	output fix_vec_t del_o  // Error terms, one clock after the inputs
);

	fix_t                ideal_val [NUM_LANES]; // Ideal bit widened to 0.0 or 1.0
	logic [DATA_WIDTH:0] diff_ext  [NUM_LANES]; // One guard bit above the sign
	fix_vec_t            del_d;                 // Saturated errors before the register

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			ideal_val[l] = ans_i[l] ? FIX_ONE : '0;

			// Sign extend both operands so the guard bit catches overflow
			diff_ext[l] = {act_i[l][DATA_WIDTH-1], act_i[l]}
				- {ideal_val[l][DATA_WIDTH-1], ideal_val[l]};

			// Guard and sign disagree means the result left the range
			if (diff_ext[l][DATA_WIDTH] != diff_ext[l][DATA_WIDTH-1]) begin
				del_d[l] = diff_ext[l][DATA_WIDTH] ? FIX_MIN : FIX_MAX; // Clamp toward true sign
			end else begin
				del_d[l] = diff_ext[l][DATA_WIDTH-1:0]; // In range, drop the guard bit
			end
		end
	end

	// Output register, lines up with the bank controller's write slot
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			del_o <= '0;
		end else begin
			del_o <= del_d;
		end
	end

endmodule

// ==== source/ideal_output_delay.sv ====
// Shift register carrying ideal output bits across the earlier layers' processing time
`timescale 1ns/100ps

module ideal_output_delay
	import dnn_geometry_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n_i,
	input  ans_vec_t ans_i, // Ideal bits entered with the sample at the first layer
	output ans_vec_t ans_o  // Same bits, aligned with the last layer's activations
);

	// One stage per clock of latency in front of the output junction
	ans_vec_t ans_sr [ANS_DELAY];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ANS_DELAY; i++) begin
				ans_sr[i] <= '0; // Empty line reads as all-zero ideal bits
			end
		end else begin
			ans_sr[0] <= ans_i; // Entry stage
			for (int i = 1; i < ANS_DELAY; i++) begin
				ans_sr[i] <= ans_sr[i-1]; // Advance one slot per clock
			end
		end
	end

	// Tap after ANS_DELAY registers
	assign ans_o = ans_sr[ANS_DELAY-1];

endmodule

// ==== source/fixed_point_pkg.sv ====
// Fixed-point number format constants, saturation limits and data types
package fixed_point_pkg;

	import dnn_geometry_pkg::*;

	// Q format, sign + integer + fraction
	localparam int DATA_WIDTH = 16;
	localparam int INT_BITS   = 5;
	localparam int FRAC_BITS  = DATA_WIDTH - INT_BITS - 1; // 10 fractional bits

	typedef logic signed [DATA_WIDTH-1:0] fix_t; // One signed fixed-point value

	// Per-lane bundle, lane 0 in the low bits
	typedef fix_t [NUM_LANES-1:0] fix_vec_t;

	// 1.0 in this format
	localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);

	// Saturation limits
	localparam fix_t FIX_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}}; // Largest positive
	localparam fix_t FIX_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}}; // Most negative

endpackage

// ==== source/dnn_geometry_pkg.sv ====
// Network shape constants, slot timing and index/address types for the output junction
package dnn_geometry_pkg;

	// Network shape
	localparam int NUM_NEURONS = 8; // Neurons in the output layer
	localparam int NUM_LANES   = 2; // Values per clock, z over fan-in
	localparam int NUM_LAYERS  = 3; // Layers in the whole network

	// Junction cycle timing
	localparam int ROWS_PER_BANK  = NUM_NEURONS / NUM_LANES; // Rows carried per junction cycle
	localparam int CLKS_PER_CYCLE = ROWS_PER_BANK + 2;       // Two spare slots per cycle
	localparam int ANS_DELAY      = CLKS_PER_CYCLE * (NUM_LAYERS - 1); // Earlier layers' latency

	// Derived widths
	localparam int CYCLE_IDX_W = $clog2(CLKS_PER_CYCLE);
	localparam int ROW_ADDR_W  = (ROWS_PER_BANK > 1) ? $clog2(ROWS_PER_BANK) : 1;

	typedef logic [CYCLE_IDX_W-1:0] cycle_idx_t; // Clock slot within a junction cycle
	typedef logic [ROW_ADDR_W-1:0]  row_addr_t;  // One row of a delta bank
	typedef logic [NUM_LANES-1:0]   ans_vec_t;   // Ideal output bit per lane
	typedef logic [NUM_LANES-1:0]   lane_we_t;   // Write enable per lane

	// Bank being written this junction cycle, the other one is read out
	typedef enum logic {
		BANK_0 = 1'b0,
		BANK_1 = 1'b1
	} bank_sel_e;

endpackage
